//--- busArbiter.sv
module busArbiter (
   input  logic clk,
   input  logic reset,
   input  mipsPkg::busReq_t fetchReq,
   input  mipsPkg::busReq_t dataReq,
   input  logic fetchValid,
   input  logic dataValid,
   output logic fetchDone,
   output logic dataDone,
   output logic [mipsPkg::dataWidth-1:0] rdata,
   output mipsPkg::apbReq_t apbOut,
   input  mipsPkg::apbRsp_t apbIn
);

   // psel and penable double as the state
   // Idle 00, setup 10, access 11
   logic psel;
   logic penable;
   logic pwrite;
   logic grantData;
   logic [mipsPkg::dataWidth-1:0] paddr;
   logic [mipsPkg::dataWidth-1:0] pwdata;
   logic complete;
   mipsPkg::busReq_t pick;

   // Data belongs to the older instruction
   assign pick = dataValid ? dataReq : fetchReq;

   assign complete = psel & penable & apbIn.pready;

   always_ff @(posedge clk) begin
      if (reset) begin
         psel <= 1'b0;
         penable <= 1'b0;
         pwrite <= 1'b0;
         grantData <= 1'b0;
      end else if (!psel) begin
         // Idle, start setup on any request
         if (dataValid || fetchValid) begin
            psel <= 1'b1;
            pwrite <= pick.write;
            grantData <= dataValid;
         end
      end else if (!penable) begin
         penable <= 1'b1;
      end else if (apbIn.pready) begin
         // Back to idle for at least one cycle
         psel <= 1'b0;
         penable <= 1'b0;
      end
   end

   // Address and write data latched while idle, steady through the transfer
   always_ff @(posedge clk) begin
      if (!psel) begin
         paddr <= pick.addr;
         pwdata <= pick.wdata;
      end
   end

   // Done pulse to the granted requester
   assign fetchDone = complete & ~grantData;
   assign dataDone = complete & grantData;
   assign rdata = apbIn.prdata;

   assign apbOut = '{paddr: paddr,
                     psel: psel,
                     penable: penable,
                     pwrite: pwrite,
                     pwdata: pwdata};

endmodule

//--- decodeStage.sv
module decodeStage (
   input  logic clk,
   input  logic reset,
   input  logic advance,
   input  mipsPkg::fetchOut_t fetched,
   input  logic [mipsPkg::dataWidth-1:0] readDataA,
   input  logic [mipsPkg::dataWidth-1:0] readDataB,
   output logic [mipsPkg::regAddrWidth-1:0] readAddrA,
   output logic [mipsPkg::regAddrWidth-1:0] readAddrB,
   input  logic wbWrite,
   input  logic [mipsPkg::regAddrWidth-1:0] wbAddr,
   input  logic [mipsPkg::dataWidth-1:0] wbData,
   output mipsPkg::decodeOut_t decoded
);

   mipsPkg::instrWord_u instr;
   mipsPkg::decodeOut_t next;
   logic signExt;

   assign instr = fetched.instr;

   // Register indices straight from the word
   assign readAddrA = instr.rFields.rs;
   assign readAddrB = instr.rFields.rt;

   always_comb begin
      // All-zero is a no-op
      next = '0;
      signExt = 1'b1;
      next.rs = instr.rFields.rs;
      next.rt = instr.rFields.rt;
      next.shamt = instr.rFields.shamt;
      next.target = instr.jFields.target;
      next.pc = fetched.pc;
      // Write-back bypass, write lands on the same edge as this register
      next.operandA = (wbWrite && wbAddr == readAddrA && wbAddr != '0) ? wbData : readDataA;
      next.operandB = (wbWrite && wbAddr == readAddrB && wbAddr != '0) ? wbData : readDataB;
      case (instr.rFields.opcode)
         mipsPkg::opRType: begin
            next.dest = instr.rFields.rd;
            next.regWrite = 1'b1;
            case (instr.rFields.funct)
               mipsPkg::fnAddu: next.aluOp = mipsPkg::aluAdd;
               mipsPkg::fnSubu: next.aluOp = mipsPkg::aluSub;
               mipsPkg::fnAnd: next.aluOp = mipsPkg::aluAnd;
               mipsPkg::fnOr: next.aluOp = mipsPkg::aluOr;
               mipsPkg::fnXor: next.aluOp = mipsPkg::aluXor;
               mipsPkg::fnSlt: next.aluOp = mipsPkg::aluSlt;
               mipsPkg::fnSll: begin
                  next.aluOp = mipsPkg::aluSll;
                  next.useShamt = 1'b1;
               end
               mipsPkg::fnSrl: begin
                  next.aluOp = mipsPkg::aluSrl;
                  next.useShamt = 1'b1;
               end
               mipsPkg::fnJr: begin
                  next.regWrite = 1'b0;
                  next.isJr = 1'b1;
               end
               // Unknown funct
               default: next.regWrite = 1'b0;
            endcase
         end
         mipsPkg::opJ: next.isJump = 1'b1;
         mipsPkg::opJal: begin
            next.isJump = 1'b1;
            next.isJal = 1'b1;
            next.regWrite = 1'b1;
            next.dest = mipsPkg::linkReg;
         end
         mipsPkg::opBeq: next.isBeq = 1'b1;
         mipsPkg::opBne: next.isBne = 1'b1;
         // Immediate ALU group writes rt
         mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opAndi,
         mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
            next.dest = instr.iFields.rt;
            next.useImm = 1'b1;
            next.regWrite = 1'b1;
         end
         mipsPkg::opLw: begin
            next.dest = instr.iFields.rt;
            next.useImm = 1'b1;
            next.regWrite = 1'b1;
            next.memRead = 1'b1;
         end
         mipsPkg::opSw: begin
            next.useImm = 1'b1;
            next.memWrite = 1'b1;
         end
         default: next.regWrite = 1'b0;
      endcase
      // ALU select and extension of the immediate group
      case (instr.iFields.opcode)
         mipsPkg::opSlti: next.aluOp = mipsPkg::aluSlt;
         mipsPkg::opAndi: begin
            next.aluOp = mipsPkg::aluAnd;
            signExt = 1'b0;
         end
         mipsPkg::opOri: begin
            next.aluOp = mipsPkg::aluOr;
            signExt = 1'b0;
         end
         mipsPkg::opXori: begin
            next.aluOp = mipsPkg::aluXor;
            signExt = 1'b0;
         end
         mipsPkg::opLui: begin
            next.aluOp = mipsPkg::aluLui;
            signExt = 1'b0;
         end
         default: signExt = 1'b1;
      endcase
      next.imm = signExt ? {{16{instr.iFields.imm[15]}}, instr.iFields.imm}
                         : {16'h0000, instr.iFields.imm};
   end

   // Decode to execute register
   always_ff @(posedge clk) begin
      if (reset) begin
         decoded <= '0;
      end else if (advance) begin
         decoded <= next;
      end
   end

endmodule

//--- executeStage.sv
module executeStage (
   input  logic clk,
   input  logic reset,
   input  logic advance,
   input  mipsPkg::decodeOut_t decoded,
   input  logic fwdValid,
   input  logic [mipsPkg::regAddrWidth-1:0] fwdAddr,
   input  logic [mipsPkg::dataWidth-1:0] fwdData,
   output mipsPkg::redirect_t redirect,
   output mipsPkg::execOut_t executed
);

   logic [mipsPkg::dataWidth-1:0] srcA;
   logic [mipsPkg::dataWidth-1:0] srcB;
   logic [mipsPkg::dataWidth-1:0] aluA;
   logic [mipsPkg::dataWidth-1:0] aluB;
   logic [mipsPkg::dataWidth-1:0] aluOut;
   logic [mipsPkg::dataWidth-1:0] pcPlus4;
   mipsPkg::execOut_t next;

   // Bypass from the memory stage
   assign srcA = (fwdValid && fwdAddr == decoded.rs && fwdAddr != '0) ? fwdData
                                                                        : decoded.operandA;
   assign srcB = (fwdValid && fwdAddr == decoded.rt && fwdAddr != '0) ? fwdData
                                                                        : decoded.operandB;

   // Shifts take their amount on the A side
   assign aluA = decoded.useShamt ? {27'd0, decoded.shamt} : srcA;
   assign aluB = decoded.useImm ? decoded.imm : srcB;

   always_comb begin
      case (decoded.aluOp)
         mipsPkg::aluSub: aluOut = aluA - aluB;
         mipsPkg::aluAnd: aluOut = aluA & aluB;
         mipsPkg::aluOr: aluOut = aluA | aluB;
         mipsPkg::aluXor: aluOut = aluA ^ aluB;
         mipsPkg::aluSlt: aluOut = {31'd0, $signed(aluA) < $signed(aluB)};
         mipsPkg::aluSll: aluOut = aluB << aluA[4:0];
         mipsPkg::aluSrl: aluOut = aluB >> aluA[4:0];
         mipsPkg::aluLui: aluOut = {aluB[15:0], 16'h0000};
         // Add, also address for lw and sw
         default: aluOut = aluA + aluB;
      endcase
   end

   assign pcPlus4 = decoded.pc + 32'd4;

   // Branch and jump resolution
   always_comb begin
      redirect.valid = (decoded.isBeq && srcA == srcB) ||
                       (decoded.isBne && srcA != srcB) ||
                       decoded.isJump || decoded.isJr;
      if (decoded.isJr) begin
         redirect.target = srcA;
      end else if (decoded.isJump) begin
         redirect.target = {pcPlus4[31:28], decoded.target, 2'b00};
      end else begin
         // Word offset relative to the delay slot
         redirect.target = pcPlus4 + {decoded.imm[29:0], 2'b00};
      end
   end

   // jal links past its delay slot
   assign next = '{aluResult: decoded.isJal ? decoded.pc + 32'd8 : aluOut,
                   storeData: srcB,
                   dest: decoded.dest,
                   regWrite: decoded.regWrite,
                   memRead: decoded.memRead,
                   memWrite: decoded.memWrite};

   // Execute to memory register
   always_ff @(posedge clk) begin
      if (reset) begin
         executed <= '0;
      end else if (advance) begin
         executed <= next;
      end
   end

endmodule

//--- fetchUnit.sv
module fetchUnit (
   input  logic clk,
   input  logic reset,
   input  mipsPkg::redirect_t redirect,
   input  logic advance,
   input  logic fetchDone,
   input  logic [mipsPkg::dataWidth-1:0] rdata,
   output mipsPkg::busReq_t fetchReq,
   output logic fetchValid,
   output logic instrReady,
   output mipsPkg::fetchOut_t fetched
);

   logic [mipsPkg::dataWidth-1:0] pc;
   mipsPkg::instrWord_u heldWord;
   logic wordValid;

   // Program counter moves only with the pipeline
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= mipsPkg::resetPc;
      end else if (advance) begin
         // Branch or jump resolved in execute this cycle
         pc <= redirect.valid ? redirect.target : pc + 32'd4;
      end
   end

   // Held word state
   // Stale after reset and after each advance, fresh on fetchDone
   always_ff @(posedge clk) begin
      if (reset) begin
         wordValid <= 1'b0;
         fetchValid <= 1'b0;
      end else if (fetchDone) begin
         wordValid <= 1'b1;
         fetchValid <= 1'b0;
      end else if (advance || !wordValid) begin
         wordValid <= 1'b0;
         fetchValid <= 1'b1;
      end
   end

   // Instruction word from the bus
   always_ff @(posedge clk) begin
      if (fetchDone) begin
         heldWord <= rdata;
      end
   end

   // Fetch is always a read at the PC
   assign fetchReq = '{addr: pc, wdata: '0, write: 1'b0};

   assign instrReady = wordValid;
   assign fetched = '{instr: heldWord, pc: pc};

endmodule

//--- memStage.sv
module memStage (
   input  logic clk,
   input  logic reset,
   input  mipsPkg::execOut_t executed,
   input  logic instrReady,
   input  logic dataDone,
   input  logic [mipsPkg::dataWidth-1:0] rdata,
   output mipsPkg::busReq_t dataReq,
   output logic dataValid,
   output logic advance,
   output logic wbWrite,
   output logic [mipsPkg::regAddrWidth-1:0] wbAddr,
   output logic [mipsPkg::dataWidth-1:0] wbData
);

   logic needAccess;
   logic accessDone;
   logic [mipsPkg::dataWidth-1:0] loadData;

   assign needAccess = executed.memRead | executed.memWrite;

   // One transfer per lw or sw
   assign dataValid = needAccess & ~accessDone;
   assign dataReq = '{addr: executed.aluResult,
                      wdata: executed.storeData,
                      write: executed.memWrite};

   // Whole pipeline moves when fetch and memory are both finished
   assign advance = instrReady & (~needAccess | accessDone);

   // Done flag cleared as the next instruction arrives
   always_ff @(posedge clk) begin
      if (reset) begin
         accessDone <= 1'b0;
      end else if (advance) begin
         accessDone <= 1'b0;
      end else if (dataDone) begin
         accessDone <= 1'b1;
      end
   end

   // Load data capture
   always_ff @(posedge clk) begin
      if (dataDone) begin
         loadData <= rdata;
      end
   end

   // Write-back, also the bypass source for execute
   assign wbWrite = executed.regWrite & advance;
   assign wbAddr = executed.dest;
   assign wbData = executed.memRead ? loadData : executed.aluResult;

endmodule

//--- mipsPkg.sv
package mipsPkg;

   // Datapath, register index and ALU select widths
   localparam int dataWidth = 32;
   localparam int regAddrWidth = 5;
   localparam int aluOpWidth = 4;

   // First fetch address
   localparam logic [dataWidth-1:0] resetPc = '0;
   // Link register written by jal
   localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

   // Primary opcodes
   localparam logic [5:0] opRType = 6'h00;
   localparam logic [5:0] opJ = 6'h02;
   localparam logic [5:0] opJal = 6'h03;
   localparam logic [5:0] opBeq = 6'h04;
   localparam logic [5:0] opBne = 6'h05;
   localparam logic [5:0] opAddiu = 6'h09;
   localparam logic [5:0] opSlti = 6'h0a;
   localparam logic [5:0] opAndi = 6'h0c;
   localparam logic [5:0] opOri = 6'h0d;
   localparam logic [5:0] opXori = 6'h0e;
   localparam logic [5:0] opLui = 6'h0f;
   localparam logic [5:0] opLw = 6'h23;
   localparam logic [5:0] opSw = 6'h2b;

   // Funct field of the R-type group
   localparam logic [5:0] fnSll = 6'h00;
   localparam logic [5:0] fnSrl = 6'h02;
   localparam logic [5:0] fnJr = 6'h08;
   localparam logic [5:0] fnAddu = 6'h21;
   localparam logic [5:0] fnSubu = 6'h23;
   localparam logic [5:0] fnAnd = 6'h24;
   localparam logic [5:0] fnOr = 6'h25;
   localparam logic [5:0] fnXor = 6'h26;
   localparam logic [5:0] fnSlt = 6'h2a;

   // ALU operations, add is the all-zero no-op default
   localparam logic [aluOpWidth-1:0] aluAdd = 4'd0;
   localparam logic [aluOpWidth-1:0] aluSub = 4'd1;
   localparam logic [aluOpWidth-1:0] aluAnd = 4'd2;
   localparam logic [aluOpWidth-1:0] aluOr = 4'd3;
   localparam logic [aluOpWidth-1:0] aluXor = 4'd4;
   localparam logic [aluOpWidth-1:0] aluSlt = 4'd5;
   localparam logic [aluOpWidth-1:0] aluSll = 4'd6;
   localparam logic [aluOpWidth-1:0] aluSrl = 4'd7;
   localparam logic [aluOpWidth-1:0] aluLui = 4'd8;

   // R format fields
   typedef struct packed {
      logic [5:0] opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } rFields_t;

   // I format fields
   typedef struct packed {
      logic [5:0] opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [15:0] imm;
   } iFields_t;

   // J format fields
   typedef struct packed {
      logic [5:0] opcode;
      logic [25:0] target;
   } jFields_t;

   // One instruction word, three views
   typedef union packed {
      rFields_t rFields;
      iFields_t iFields;
      jFields_t jFields;
   } instrWord_u;

   // Held instruction and its address
   typedef struct packed {
      instrWord_u instr;
      logic [dataWidth-1:0] pc;
   } fetchOut_t;

   // Decode to execute register contents
   typedef struct packed {
      logic [dataWidth-1:0] operandA;
      logic [dataWidth-1:0] operandB;
      logic [dataWidth-1:0] imm;
      logic [4:0] shamt;
      logic [regAddrWidth-1:0] dest;
      logic [aluOpWidth-1:0] aluOp;
      logic useImm;
      logic useShamt;
      logic regWrite;
      logic memRead;
      logic memWrite;
      logic isBeq;
      logic isBne;
      logic isJump;
      logic isJr;
      logic isJal;
      logic [25:0] target;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [dataWidth-1:0] pc;
   } decodeOut_t;

   // Taken branch or jump
   typedef struct packed {
      logic valid;
      logic [dataWidth-1:0] target;
   } redirect_t;

   // Execute to memory register contents
   typedef struct packed {
      logic [dataWidth-1:0] aluResult;
      logic [dataWidth-1:0] storeData;
      logic [regAddrWidth-1:0] dest;
      logic regWrite;
      logic memRead;
      logic memWrite;
   } execOut_t;

   // Requester side of the arbiter
   typedef struct packed {
      logic [dataWidth-1:0] addr;
      logic [dataWidth-1:0] wdata;
      logic write;
   } busReq_t;

   // APB master outputs
   typedef struct packed {
      logic [dataWidth-1:0] paddr;
      logic psel;
      logic penable;
      logic pwrite;
      logic [dataWidth-1:0] pwdata;
   } apbReq_t;

   // APB slave response
   typedef struct packed {
      logic [dataWidth-1:0] prdata;
      logic pready;
   } apbRsp_t;

endpackage

//--- regFile.sv
module regFile (
   input  logic clk,
   input  logic [mipsPkg::regAddrWidth-1:0] readAddrA,
   input  logic [mipsPkg::regAddrWidth-1:0] readAddrB,
   input  logic writeEn,
   input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
   input  logic [mipsPkg::dataWidth-1:0] writeData,
   output logic [mipsPkg::dataWidth-1:0] readDataA,
   output logic [mipsPkg::dataWidth-1:0] readDataB
);

   logic [mipsPkg::dataWidth-1:0] regs [32];

   // Single write port, register 0 never written
   always_ff @(posedge clk) begin
      if (writeEn && writeAddr != '0) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Asynchronous reads
   // Register 0 reads as zero
   assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- storeChecker.sv
module storeChecker (
   input  logic clk,
   input  logic reset,
   input  mipsPkg::apbReq_t apbOut,
   input  mipsPkg::apbRsp_t apbIn,
   output logic done,
   output int errorCount
);

   // Expected stores in program order
   logic [31:0] expAddr [0:63];
   logic [31:0] expData [0:63];
   int expTest [0:63];
   int expCount = 0;
   int seenCount = 0;
   // Running totals for the current test
   int testMismatches = 0;
   int testStores = 0;
   int testsPassed = 0;
   int testsFailed = 0;
   logic lastOfTest;

   initial begin
      done = 1'b0;
      errorCount = 0;
   end

   task automatic expectStore(input logic [31:0] addr, input logic [31:0] data,
                              input int testNum);
      if (expCount < 64) begin
         expAddr[expCount] = addr;
         expData[expCount] = data;
         expTest[expCount] = testNum;
         expCount++;
      end else begin
         $display("Expected store list is full, store for test %0d dropped", testNum);
         errorCount++;
      end
   endtask

   task automatic printCounts();
      $display("Counts: %0d tests passed, %0d tests failed, %0d of %0d stores seen, %0d errors",
               testsPassed, testsFailed, seenCount, expCount, errorCount + testMismatches);
   endtask

   task automatic reportMissing();
      if (seenCount < expCount) begin
         $display("Timed out: %0d expected stores never appeared, next one test %0d at %h",
                  expCount - seenCount, expTest[seenCount], expAddr[seenCount]);
      end else begin
         $display("Timed out after every expected store was seen");
      end
      printCounts();
   endtask

   // Completed APB write transfers sampled like the DUT
   always @(posedge clk) begin
      if (!reset && apbOut.psel && apbOut.penable && apbOut.pwrite && apbIn.pready) begin
         if (seenCount >= expCount) begin
            $display("Unexpected store at time %0t of %h to %h after the last expected one",
                     $time, apbOut.pwdata, apbOut.paddr);
            errorCount++;
         end else begin
            if (apbOut.paddr !== expAddr[seenCount]) begin
               $display("FAILED at time %0t: paddr expected %h actual %h",
                        $time, expAddr[seenCount], apbOut.paddr);
               testMismatches++;
            end
            if (apbOut.pwdata !== expData[seenCount]) begin
               $display("FAILED at time %0t: pwdata expected %h actual %h",
                        $time, expData[seenCount], apbOut.pwdata);
               testMismatches++;
            end
            testStores++;
            seenCount++;
            // Test ends where the next record has another test number
            lastOfTest = (seenCount == expCount) ||
                         (expTest[seenCount] != expTest[seenCount - 1]);
            if (lastOfTest) begin
               if (testMismatches == 0) begin
                  $display("Test %0d passed, %0d stores matched",
                           expTest[seenCount - 1], testStores);
                  testsPassed++;
               end else begin
                  $display("Test %0d failed, %0d mismatches in %0d stores",
                           expTest[seenCount - 1], testMismatches, testStores);
                  testsFailed++;
               end
               errorCount += testMismatches;
               testMismatches = 0;
               testStores = 0;
            end
            if (seenCount == expCount) begin
               done = 1'b1;
            end
         end
      end
   end

endmodule

//--- tb_threeStageMips.sv
module tb_threeStageMips;

   logic clk;
   logic reset = 1'b1;
   mipsPkg::apbReq_t apbOut;
   mipsPkg::apbRsp_t apbIn = '0;

   // Raw data file words and the 4 KB memory behind the APB port
   logic [31:0] testData [0:255];
   logic [31:0] mem [0:1023];
   int wordCount;
   int storeCount;
   longint watchdogTime = 0;

   // Slave wait states
   integer seed = 32'h3a0e_29d0;
   int waitCycles;
   int waitLeft;

   logic checkDone;
   int checkErrors;

   threeStageMips u_threeStageMips (
      .clk(clk),
      .reset(reset),
      .apbOut(apbOut),
      .apbIn(apbIn)
   );

   storeChecker u_storeChecker (
      .clk(clk),
      .reset(reset),
      .apbOut(apbOut),
      .apbIn(apbIn),
      .done(checkDone),
      .errorCount(checkErrors)
   );

   bind threeStageMips threeStageMips_sva u_apbSva (
      .clk(clk),
      .reset(reset),
      .apbOut(apbOut),
      .apbIn(apbIn)
   );

   // Unsupported opcode in the top bits makes stray fetches no-ops
   function automatic logic [31:0] fillWord(input logic [31:0] addr);
      return addr ^ 32'hbad0_5a5a;
   endfunction

   function automatic logic [31:0] readWord(input logic [31:0] addr);
      if (addr[31:12] == '0) begin
         return mem[addr[11:2]];
      end
      return fillWord(addr);
   endfunction

   // Counts completed APB transfers of any kind
   task automatic drainTransfers(input int count);
      int seen;
      seen = 0;
      while (seen < count) begin
         @(posedge clk);
         if (apbOut.psel && apbOut.penable && apbIn.pready) begin
            seen++;
         end
      end
   endtask

   // 40 time unit clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      repeat (8) @(posedge clk);
      reset <= 1'b0;
   end

   // APB slave with 0 to 3 wait states per transfer
   always @(posedge clk) begin
      if (reset) begin
         apbIn.pready <= 1'b0;
         waitLeft <= 0;
      end else if (apbOut.psel && !apbOut.penable) begin
         waitCycles = $random(seed) & 3;
         waitLeft <= waitCycles;
         apbIn.pready <= (waitCycles == 0);
         apbIn.prdata <= readWord(apbOut.paddr);
      end else if (apbOut.psel && apbOut.penable) begin
         if (apbIn.pready) begin
            apbIn.pready <= 1'b0;
            if (apbOut.pwrite && apbOut.paddr[31:12] == '0) begin
               mem[apbOut.paddr[11:2]] = apbOut.pwdata;
            end
         end else if (waitLeft <= 1) begin
            apbIn.pready <= 1'b1;
         end else begin
            waitLeft <= waitLeft - 1;
         end
      end
   end

   // Limit from program size and store count
   initial begin
      wait (watchdogTime != 0);
      #(watchdogTime);
      u_storeChecker.reportMissing();
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin : runTest
      int base;
      logic [31:0] addr;
      $readmemh("threeStageMips_testdata.txt", testData);
      if ($isunknown(testData[0]) || $isunknown(testData[1])) begin
         $display("Test data file missing or unreadable");
         $display("TEST RESULT: FAIL");
         $finish;
      end else begin
         wordCount = testData[0];
         storeCount = testData[1];
         for (int i = 0; i < 1024; i++) begin
            mem[i] = fillWord(i * 4);
         end
         // Program and data records
         for (int i = 0; i < wordCount; i++) begin
            addr = testData[2 + 2 * i];
            mem[addr[11:2]] = testData[3 + 2 * i];
         end
         // Expected stores follow the memory records
         base = 2 + 2 * wordCount;
         for (int i = 0; i < storeCount; i++) begin
            u_storeChecker.expectStore(testData[base + 3 * i], testData[base + 3 * i + 1],
                                       testData[base + 3 * i + 2]);
         end
         // 40 cycles per record
         watchdogTime = longint'(storeCount + wordCount) * 40 * 40;
         wait (checkDone);
         // A store skipped by the closing jump would reach the bus within a few transfers
         drainTransfers(8);
         @(posedge clk);
         u_storeChecker.printCounts();
         if (checkErrors == 0 && u_threeStageMips.u_apbSva.failCount == 0) begin
            $display("TEST RESULT: PASS");
         end else begin
            $display("TEST RESULT: FAIL");
         end
         $finish;
      end
   end

endmodule

//--- threeStageMips.f
mipsPkg.sv
fetchUnit.sv
regFile.sv
decodeStage.sv
executeStage.sv
memStage.sv
busArbiter.sv
threeStageMips.sv
threeStageMips_sva.sv
storeChecker.sv
tb_threeStageMips.sv

//--- threeStageMips.sv
module threeStageMips (
   input  logic clk,
   input  logic reset,
   output mipsPkg::apbReq_t apbOut,
   input  mipsPkg::apbRsp_t apbIn
);

   // Fetch and bus handshake
   mipsPkg::busReq_t fetchReq;
   mipsPkg::busReq_t dataReq;
   logic fetchValid;
   logic dataValid;
   logic fetchDone;
   logic dataDone;
   logic [mipsPkg::dataWidth-1:0] rdata;

   // Stage outputs
   mipsPkg::fetchOut_t fetched;
   mipsPkg::decodeOut_t decoded;
   mipsPkg::execOut_t executed;
   mipsPkg::redirect_t redirect;
   logic instrReady;
   logic advance;

   // Register file ports and write-back
   logic [mipsPkg::regAddrWidth-1:0] readAddrA;
   logic [mipsPkg::regAddrWidth-1:0] readAddrB;
   logic [mipsPkg::dataWidth-1:0] readDataA;
   logic [mipsPkg::dataWidth-1:0] readDataB;
   logic wbWrite;
   logic [mipsPkg::regAddrWidth-1:0] wbAddr;
   logic [mipsPkg::dataWidth-1:0] wbData;

   fetchUnit u_fetchUnit (
      .clk(clk),
      .reset(reset),
      .redirect(redirect),
      .advance(advance),
      .fetchDone(fetchDone),
      .rdata(rdata),
      .fetchReq(fetchReq),
      .fetchValid(fetchValid),
      .instrReady(instrReady),
      .fetched(fetched)
   );

   regFile u_regFile (
      .clk(clk),
      .readAddrA(readAddrA),
      .readAddrB(readAddrB),
      .writeEn(wbWrite),
      .writeAddr(wbAddr),
      .writeData(wbData),
      .readDataA(readDataA),
      .readDataB(readDataB)
   );

   decodeStage u_decodeStage (
      .clk(clk),
      .reset(reset),
      .advance(advance),
      .fetched(fetched),
      .readDataA(readDataA),
      .readDataB(readDataB),
      .readAddrA(readAddrA),
      .readAddrB(readAddrB),
      .wbWrite(wbWrite),
      .wbAddr(wbAddr),
      .wbData(wbData),
      .decoded(decoded)
   );

   // Memory stage write-back doubles as the execute bypass
   executeStage u_executeStage (
      .clk(clk),
      .reset(reset),
      .advance(advance),
      .decoded(decoded),
      .fwdValid(wbWrite),
      .fwdAddr(wbAddr),
      .fwdData(wbData),
      .redirect(redirect),
      .executed(executed)
   );

   memStage u_memStage (
      .clk(clk),
      .reset(reset),
      .executed(executed),
      .instrReady(instrReady),
      .dataDone(dataDone),
      .rdata(rdata),
      .dataReq(dataReq),
      .dataValid(dataValid),
      .advance(advance),
      .wbWrite(wbWrite),
      .wbAddr(wbAddr),
      .wbData(wbData)
   );

   busArbiter u_busArbiter (
      .clk(clk),
      .reset(reset),
      .fetchReq(fetchReq),
      .dataReq(dataReq),
      .fetchValid(fetchValid),
      .dataValid(dataValid),
      .fetchDone(fetchDone),
      .dataDone(dataDone),
      .rdata(rdata),
      .apbOut(apbOut),
      .apbIn(apbIn)
   );

endmodule

//--- threeStageMips_sva.sv
module threeStageMips_sva (
   input  logic clk,
   input  logic reset,
   input  mipsPkg::apbReq_t apbOut,
   input  mipsPkg::apbRsp_t apbIn
);

   // Failures seen by the testbench top
   int failCount = 0;

   logic setupPhase;
   logic accessPhase;
   logic completing;

   assign setupPhase = apbOut.psel & ~apbOut.penable;
   assign accessPhase = apbOut.psel & apbOut.penable;
   assign completing = accessPhase & apbIn.pready;

   // Setup lasts exactly one cycle
   setupThenAccess: assert property (@(posedge clk) disable iff (reset)
      setupPhase |=> accessPhase)
      else begin
         $error("APB setup cycle not followed by an access cycle");
         failCount++;
      end

   // Transfer attributes held until the completing cycle
   attributesHeld: assert property (@(posedge clk) disable iff (reset)
      (apbOut.psel && !completing) |=>
         ($stable(apbOut.paddr) && $stable(apbOut.pwrite) && $stable(apbOut.pwdata)))
      else begin
         $error("APB paddr, pwrite or pwdata changed during a transfer");
         failCount++;
      end

   // At least one idle cycle between transfers
   idleAfterReady: assert property (@(posedge clk) disable iff (reset)
      completing |=> !apbOut.psel)
      else begin
         $error("APB psel still high after the completing cycle");
         failCount++;
      end

endmodule

//--- threeStageMips_testdata.txt
// Counts first (memory records, expected stores), then memory records as: address data
// then expected stores in program order as: address data test
0000003f 0000001b
// Test 1, immediate and register ALU operations
00000000 24011234
00000004 2402fff0
00000008 3c03a5a5
0000000c 34640f0f
00000010 3085ff00
00000014 3886ffff
00000018 28470001
0000001c 00224021
00000020 00244823
00000024 00865024
00000028 00a15825
0000002c 00866026
00000030 0081682a
00000034 00017100
00000038 00047a02
0000003c ac010300
00000040 ac020304
00000044 ac030308
00000048 ac04030c
0000004c ac050310
00000050 ac060314
00000054 ac070318
00000058 ac08031c
0000005c ac090320
00000060 ac0a0324
00000064 ac0b0328
00000068 ac0c032c
0000006c ac0d0330
00000070 ac0e0334
00000074 ac0f0338
// Test 2, back-to-back dependences
00000078 24300001
0000007c 02108821
00000080 02309023
00000084 ac120340
00000088 ac110344
// Test 3, load then immediate use
0000008c 8c130200
00000090 26740123
00000094 ac140348
// Test 4, beq and bne with delay slots
00000098 12120002
0000009c ac010350
000000a0 ac020354
000000a4 16120002
000000a8 ac030358
000000ac ac05035c
000000b0 24150007
000000b4 16b00002
000000b8 ac150360
000000bc ac060364
000000c0 12a00002
000000c4 ac070368
000000c8 ac09036c
// Test 5, jal, jr and j, then a closing self loop
000000cc 0c000040
000000d0 24160055
000000d4 ac160370
000000d8 08000039
000000dc 24170001
000000e0 ac170374
000000e4 08000039
000000e8 00000000
00000100 ac1f0378
00000104 03e00008
00000108 ac16037c
// Preloaded data word
00000200 13579bd0
// Expected stores
00000300 00001234 1
00000304 fffffff0 1
00000308 a5a50000 1
0000030c a5a50f0f 1
00000310 00000f00 1
00000314 a5a5f0f0 1
00000318 00000001 1
0000031c 00001224 1
00000320 5a5b0325 1
00000324 a5a50000 1
00000328 00001f34 1
0000032c 0000ffff 1
00000330 00000001 1
00000334 00012340 1
00000338 00a5a50f 1
00000340 00001235 2
00000344 0000246a 2
00000348 13579cf3 3
00000350 00001234 4
00000358 a5a50000 4
0000035c 00000f00 4
00000360 00000007 4
00000368 00000001 4
0000036c 5a5b0325 4
00000378 000000d4 5
0000037c 00000055 5
00000370 00000055 5
